// File: logic/id_pkg.sv
package id_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data and address width
  localparam int XLEN      = 32;
  // Register index width
  localparam int RF_ADDR_W = 5;
  // Register count, x0 included
  localparam int NUM_REGS  = 2 ** RF_ADDR_W;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [XLEN-1:0]      word_t;

  ////////////////////
  // Opcodes
  ////////////////////

  // RV32I major opcodes handled by this stage
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opcode_e;

  // ALU operation, comparisons last
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  ////////////////////
  // Mux selects
  ////////////////////

  typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} op_a_sel_e;
  typedef enum logic {OPB_REG, OPB_IMM} op_b_sel_e;
  // IMMB_PCINCR is the constant 4, link address for jumps
  typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {OPC_REGB, OPC_BCH, OPC_ZERO} op_c_sel_e;

  // Forwarding selects, driven by the controller
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;
  typedef enum logic {SELJ_REGFILE, SELJ_FW_WB} jalr_fw_sel_e;

  // Control transfer kind
  typedef enum logic [1:0] {XFER_NONE, XFER_JAL, XFER_JALR, XFER_BRANCH} xfer_e;

endpackage

// File: logic/id_decoder.sv
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
  input  word_t      instr_i,
  output alu_op_e    alu_operator_o,
  output op_a_sel_e  op_a_sel_o,
  output op_b_sel_e  op_b_sel_o,
  output imm_b_sel_e imm_b_sel_o,
  output op_c_sel_e  op_c_sel_o,
  output word_t      imm_i_o,
  output word_t      imm_s_o,
  output word_t      imm_sb_o,
  output word_t      imm_u_o,
  output word_t      imm_uj_o,
  output logic       rf_we_o,
  output logic       data_req_o,
  output logic       data_we_o,
  output logic       illegal_o,
  output logic [1:0] data_type_o,
  output xfer_e      xfer_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Shared funct3 map of OP and OP-IMM
  function automatic alu_op_e base_alu_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Immediates, all sign extended from bit 31
  assign imm_i_o  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_o  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
  assign imm_u_o  = {instr_i[31:12], 12'b0};
  assign imm_uj_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // Access size straight from funct3
  assign data_type_o = funct3[1:0];

  always_comb begin
    // Defaults: reg + reg add, no side effects
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OPA_REG;
    op_b_sel_o     = OPB_REG;
    imm_b_sel_o    = IMMB_I;
    op_c_sel_o     = OPC_ZERO;
    rf_we_o        = 1'b0;
    data_req_o     = 1'b0;
    data_we_o      = 1'b0;
    illegal_o      = 1'b0;
    xfer_o         = XFER_NONE;

    case (opcode)
      LUI, AUIPC: begin
        // Zero or PC plus upper immediate
        op_a_sel_o  = (opcode == LUI) ? OPA_ZERO : OPA_PC;
        op_b_sel_o  = OPB_IMM;
        imm_b_sel_o = IMMB_U;
        rf_we_o     = 1'b1;
      end
      JAL, JALR: begin
        // Link address is PC + 4
        op_a_sel_o  = OPA_PC;
        op_b_sel_o  = OPB_IMM;
        imm_b_sel_o = IMMB_PCINCR;
        rf_we_o     = 1'b1;
        xfer_o      = (opcode == JAL) ? XFER_JAL : XFER_JALR;
        if (opcode == JALR && funct3 != 3'b000) illegal_o = 1'b1;
      end
      BRANCH: begin
        op_c_sel_o = OPC_BCH;
        xfer_o     = XFER_BRANCH;
        case (funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end
      LOAD: begin
        op_b_sel_o = OPB_IMM;
        rf_we_o    = 1'b1;
        data_req_o = 1'b1;
        // lb lh lw lbu lhu only
        if (funct3 == 3'b011 || funct3[2:1] == 2'b11) illegal_o = 1'b1;
      end
      STORE: begin
        // Store data rides on operand C
        op_b_sel_o  = OPB_IMM;
        imm_b_sel_o = IMMB_S;
        op_c_sel_o  = OPC_REGB;
        data_req_o  = 1'b1;
        data_we_o   = 1'b1;
        if (funct3[2] || funct3[1:0] == 2'b11) illegal_o = 1'b1;
      end
      OP_IMM: begin
        op_b_sel_o     = OPB_IMM;
        rf_we_o        = 1'b1;
        alu_operator_o = base_alu_op(funct3);
        // Shift amount field, funct7 picks srai
        if (funct3 == 3'b001 && funct7 != 7'b0) illegal_o = 1'b1;
        if (funct3 == 3'b101) begin
          if (funct7 == 7'b0100000) alu_operator_o = ALU_SRA;
          else if (funct7 != 7'b0) illegal_o = 1'b1;
        end
      end
      OP: begin
        rf_we_o        = 1'b1;
        alu_operator_o = base_alu_op(funct3);
        if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) alu_operator_o = ALU_SUB;
          else if (funct3 == 3'b101) alu_operator_o = ALU_SRA;
          else illegal_o = 1'b1;
        end else if (funct7 != 7'b0) begin
          illegal_o = 1'b1;
        end
      end
      default: illegal_o = 1'b1;
    endcase

    // Kill every side effect of an illegal word
    if (illegal_o) begin
      rf_we_o    = 1'b0;
      data_req_o = 1'b0;
      data_we_o  = 1'b0;
      xfer_o     = XFER_NONE;
    end
  end

endmodule

// File: logic/id_regfile.sv
`timescale 1ns/1ps

module id_regfile import id_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  rf_addr_t raddr_a_i,
  input  rf_addr_t raddr_b_i,
  output word_t    rdata_a_o,
  output word_t    rdata_b_o,
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  word_t    wdata_i
);

  // x1..x31, x0 has no storage
  word_t regs [1:NUM_REGS-1];

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // No bypass, a write shows up the cycle after
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: logic/id_operand_select.sv
`timescale 1ns/1ps

module id_operand_select import id_pkg::*; (
  input  word_t        pc_i,
  input  word_t        rdata_a_i,
  input  word_t        rdata_b_i,
  input  word_t        fw_ex_i,
  input  word_t        fw_wb_i,
  input  fw_sel_e      fw_a_sel_i,
  input  fw_sel_e      fw_b_sel_i,
  input  jalr_fw_sel_e jalr_fw_sel_i,
  input  op_a_sel_e    op_a_sel_i,
  input  op_b_sel_e    op_b_sel_i,
  input  imm_b_sel_e   imm_b_sel_i,
  input  op_c_sel_e    op_c_sel_i,
  input  word_t        imm_i_i,
  input  word_t        imm_s_i,
  input  word_t        imm_sb_i,
  input  word_t        imm_u_i,
  input  word_t        imm_uj_i,
  input  xfer_e        xfer_i,
  output word_t        operand_a_o,
  output word_t        operand_b_o,
  output word_t        operand_c_o,
  output word_t        jmp_target_o
);

  word_t operand_a_fw;
  word_t operand_b_fw;
  word_t jalr_base;
  word_t imm_b;
  word_t bch_target;

  // Same forwarding mux for both register operands
  function automatic word_t fw_mux(input fw_sel_e sel, input word_t rf, input word_t ex,
                                   input word_t wb);
    case (sel)
      SEL_FW_EX: return ex;
      SEL_FW_WB: return wb;
      default:   return rf;
    endcase
  endfunction

  assign operand_a_fw = fw_mux(fw_a_sel_i, rdata_a_i, fw_ex_i, fw_wb_i);
  assign operand_b_fw = fw_mux(fw_b_sel_i, rdata_b_i, fw_ex_i, fw_wb_i);
  // JALR base only sees the WB path
  assign jalr_base    = (jalr_fw_sel_i == SELJ_FW_WB) ? fw_wb_i : rdata_a_i;

  // Operand A
  always_comb begin
    case (op_a_sel_i)
      OPA_REG: operand_a_o = operand_a_fw;
      OPA_PC:  operand_a_o = pc_i;
      default: operand_a_o = '0;
    endcase
  end

  // Operand B, register or one of the immediates
  always_comb begin
    case (imm_b_sel_i)
      IMMB_S:      imm_b = imm_s_i;
      IMMB_U:      imm_b = imm_u_i;
      IMMB_PCINCR: imm_b = 32'd4;
      default:     imm_b = imm_i_i;
    endcase
  end
  assign operand_b_o = (op_b_sel_i == OPB_IMM) ? imm_b : operand_b_fw;

  // Operand C, store data or branch target
  assign bch_target = pc_i + imm_sb_i;
  always_comb begin
    case (op_c_sel_i)
      OPC_REGB: operand_c_o = operand_b_fw;
      OPC_BCH:  operand_c_o = bch_target;
      default:  operand_c_o = '0;
    endcase
  end

  // Jump target, JALR drops bit 0
  always_comb begin
    case (xfer_i)
      XFER_JALR:   jmp_target_o = (jalr_base + imm_i_i) & ~32'h1;
      XFER_BRANCH: jmp_target_o = bch_target;
      default:     jmp_target_o = pc_i + imm_uj_i;
    endcase
  end

endmodule

// File: logic/id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register import id_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ex_ready_i,
  input  logic       load_stall_i,
  input  logic       jr_stall_i,
  input  logic       halt_id_i,
  input  logic       branch_decision_i,
  input  alu_op_e    alu_operator_i,
  input  word_t      operand_a_i,
  input  word_t      operand_b_i,
  input  word_t      operand_c_i,
  input  logic       rf_we_i,
  input  rf_addr_t   rd_i,
  input  logic       data_req_i,
  input  logic       data_we_i,
  input  logic [1:0] data_type_i,
  input  xfer_e      xfer_i,
  input  logic       illegal_i,
  input  word_t      pc_i,
  output logic       id_ready_o,
  output logic       id_valid_o,
  output logic       clear_instr_valid_o,
  output logic       branch_taken_ex_o,
  output logic       ex_alu_en_o,
  output alu_op_e    ex_alu_operator_o,
  output word_t      ex_operand_a_o,
  output word_t      ex_operand_b_o,
  output word_t      ex_operand_c_o,
  output logic       ex_rf_we_o,
  output rf_addr_t   ex_rf_waddr_o,
  output logic       ex_data_req_o,
  output logic       ex_data_we_o,
  output logic [1:0] ex_data_type_o,
  output logic       ex_branch_in_ex_o,
  output logic       ex_illegal_insn_o,
  output word_t      ex_pc_o
);

  logic alu_en;

  // Every legal opcode here goes through the ALU
  assign alu_en = ~illegal_i;

  ////////////////////
  // Stall control
  ////////////////////

  assign id_ready_o          = ex_ready_i & ~load_stall_i & ~jr_stall_i;
  assign id_valid_o          = id_ready_o & ~halt_id_i;
  assign clear_instr_valid_o = id_ready_o | halt_id_i | branch_taken_ex_o;
  assign branch_taken_ex_o   = ex_branch_in_ex_o & branch_decision_i;

  ////////////////////
  // ID/EX register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ex_alu_en_o       <= 1'b0;
      ex_alu_operator_o <= ALU_ADD;
      ex_operand_a_o    <= '0;
      ex_operand_b_o    <= '0;
      ex_operand_c_o    <= '0;
      ex_rf_we_o        <= 1'b0;
      ex_rf_waddr_o     <= '0;
      ex_data_req_o     <= 1'b0;
      ex_data_we_o      <= 1'b0;
      ex_data_type_o    <= 2'b00;
      ex_branch_in_ex_o <= 1'b0;
      ex_illegal_insn_o <= 1'b0;
      ex_pc_o           <= '0;
    end else if (id_valid_o) begin
      // Advance
      ex_alu_en_o <= alu_en;
      if (alu_en) begin
        ex_alu_operator_o <= alu_operator_i;
        ex_operand_a_o    <= operand_a_i;
        ex_operand_b_o    <= operand_b_i;
        ex_operand_c_o    <= operand_c_i;
      end
      ex_rf_we_o    <= rf_we_i;
      ex_rf_waddr_o <= rd_i;
      ex_data_req_o <= data_req_i;
      // LSU fields only matter with a request
      if (data_req_i) begin
        ex_data_we_o   <= data_we_i;
        ex_data_type_o <= data_type_i;
      end
      ex_branch_in_ex_o <= (xfer_i == XFER_BRANCH);
      ex_illegal_insn_o <= illegal_i;
      ex_pc_o           <= pc_i;
    end else if (ex_ready_i) begin
      // Bubble, payload left as is
      ex_alu_en_o       <= 1'b0;
      ex_rf_we_o        <= 1'b0;
      ex_data_req_o     <= 1'b0;
      ex_branch_in_ex_o <= 1'b0;
      ex_illegal_insn_o <= 1'b0;
    end
    // EX not ready: hold
  end

endmodule

// File: logic/id_stage_top.sv
`timescale 1ns/1ps

module id_stage_top import id_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  word_t        instr_i,
  input  word_t        pc_i,
  input  logic         ex_ready_i,
  input  logic         load_stall_i,
  input  logic         jr_stall_i,
  input  logic         halt_id_i,
  input  logic         branch_decision_i,
  input  fw_sel_e      fw_a_sel_i,
  input  fw_sel_e      fw_b_sel_i,
  input  jalr_fw_sel_e jalr_fw_sel_i,
  input  word_t        rf_wdata_ex_i,
  input  logic         rf_we_wb_i,
  input  rf_addr_t     rf_waddr_wb_i,
  input  word_t        rf_wdata_wb_i,
  output logic         id_ready_o,
  output logic         id_valid_o,
  output logic         clear_instr_valid_o,
  output logic         branch_taken_ex_o,
  output word_t        jmp_target_o,
  output logic         ex_alu_en_o,
  output alu_op_e      ex_alu_operator_o,
  output word_t        ex_operand_a_o,
  output word_t        ex_operand_b_o,
  output word_t        ex_operand_c_o,
  output logic         ex_rf_we_o,
  output rf_addr_t     ex_rf_waddr_o,
  output logic         ex_data_req_o,
  output logic         ex_data_we_o,
  output logic [1:0]   ex_data_type_o,
  output logic         ex_branch_in_ex_o,
  output logic         ex_illegal_insn_o,
  output word_t        ex_pc_o
);

  // Decoder outputs
  alu_op_e    alu_operator;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;
  op_c_sel_e  op_c_sel;
  word_t      imm_i, imm_s, imm_sb, imm_u, imm_uj;
  logic       rf_we, data_req, data_we, illegal;
  logic [1:0] data_type;
  xfer_e      xfer;
  // Register file and operand paths
  word_t      rdata_a, rdata_b;
  word_t      operand_a, operand_b, operand_c;

  ////////////////////
  // Decode
  ////////////////////

  id_decoder u_decoder (
    .instr_i        (instr_i),
    .alu_operator_o (alu_operator),
    .op_a_sel_o     (op_a_sel),
    .op_b_sel_o     (op_b_sel),
    .imm_b_sel_o    (imm_b_sel),
    .op_c_sel_o     (op_c_sel),
    .imm_i_o        (imm_i),
    .imm_s_o        (imm_s),
    .imm_sb_o       (imm_sb),
    .imm_u_o        (imm_u),
    .imm_uj_o       (imm_uj),
    .rf_we_o        (rf_we),
    .data_req_o     (data_req),
    .data_we_o      (data_we),
    .illegal_o      (illegal),
    .data_type_o    (data_type),
    .xfer_o         (xfer)
  );

  // rs1 and rs2 fields
  id_regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (instr_i[19:15]),
    .raddr_b_i (instr_i[24:20]),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we_wb_i),
    .waddr_i   (rf_waddr_wb_i),
    .wdata_i   (rf_wdata_wb_i)
  );

  ////////////////////
  // Operands
  ////////////////////

  id_operand_select u_operand_select (
    .pc_i          (pc_i),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .fw_ex_i       (rf_wdata_ex_i),
    .fw_wb_i       (rf_wdata_wb_i),
    .fw_a_sel_i    (fw_a_sel_i),
    .fw_b_sel_i    (fw_b_sel_i),
    .jalr_fw_sel_i (jalr_fw_sel_i),
    .op_a_sel_i    (op_a_sel),
    .op_b_sel_i    (op_b_sel),
    .imm_b_sel_i   (imm_b_sel),
    .op_c_sel_i    (op_c_sel),
    .imm_i_i       (imm_i),
    .imm_s_i       (imm_s),
    .imm_sb_i      (imm_sb),
    .imm_u_i       (imm_u),
    .imm_uj_i      (imm_uj),
    .xfer_i        (xfer),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jmp_target_o  (jmp_target_o)
  );

  ////////////////////
  // Pipeline register
  ////////////////////

  // rd is the raw instr[11:7] field
  id_ex_register u_id_ex_register (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ex_ready_i          (ex_ready_i),
    .load_stall_i        (load_stall_i),
    .jr_stall_i          (jr_stall_i),
    .halt_id_i           (halt_id_i),
    .branch_decision_i   (branch_decision_i),
    .alu_operator_i      (alu_operator),
    .operand_a_i         (operand_a),
    .operand_b_i         (operand_b),
    .operand_c_i         (operand_c),
    .rf_we_i             (rf_we),
    .rd_i                (instr_i[11:7]),
    .data_req_i          (data_req),
    .data_we_i           (data_we),
    .data_type_i         (data_type),
    .xfer_i              (xfer),
    .illegal_i           (illegal),
    .pc_i                (pc_i),
    .id_ready_o          (id_ready_o),
    .id_valid_o          (id_valid_o),
    .clear_instr_valid_o (clear_instr_valid_o),
    .branch_taken_ex_o   (branch_taken_ex_o),
    .ex_alu_en_o         (ex_alu_en_o),
    .ex_alu_operator_o   (ex_alu_operator_o),
    .ex_operand_a_o      (ex_operand_a_o),
    .ex_operand_b_o      (ex_operand_b_o),
    .ex_operand_c_o      (ex_operand_c_o),
    .ex_rf_we_o          (ex_rf_we_o),
    .ex_rf_waddr_o       (ex_rf_waddr_o),
    .ex_data_req_o       (ex_data_req_o),
    .ex_data_we_o        (ex_data_we_o),
    .ex_data_type_o      (ex_data_type_o),
    .ex_branch_in_ex_o   (ex_branch_in_ex_o),
    .ex_illegal_insn_o   (ex_illegal_insn_o),
    .ex_pc_o             (ex_pc_o)
  );

endmodule

// File: bench/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage
  import id_pkg::*;
();

  localparam int    NUM_ROWS  = 21;
  localparam int    READY_MAX = 20;
  localparam word_t FW_EX_VAL = 32'h00AB_CD00;
  localparam word_t FW_WB_VAL = 32'h0001_2347;

  // One table row, stimulus first then expected EX state
  typedef struct packed {
    word_t        instr;
    word_t        pc;
    fw_sel_e      fw_a;
    fw_sel_e      fw_b;
    jalr_fw_sel_e fw_j;
    logic [3:0]   lvl;      // ex_ready, load_stall, jr_stall, halt
    logic         bdec;     // branch decision while this row sits in EX
    word_t        op_a;
    word_t        op_b;
    word_t        op_c;
    alu_op_e      alu_op;
    logic         rf_we;
    rf_addr_t     rd;
    logic         req;
    logic         dwe;
    logic [1:0]   dtype;
    logic         ill;
    logic         taken;
    logic         jmp_chk;
    word_t        jmp;
    logic         alu_en;
    logic         br_in_ex;
    word_t        ex_pc;
  } row_t;

  logic         clk;
  logic         rst_n;
  word_t        instr_i;
  word_t        pc_i;
  logic         ex_ready_i;
  logic         load_stall_i;
  logic         jr_stall_i;
  logic         halt_id_i;
  logic         branch_decision_i;
  fw_sel_e      fw_a_sel_i;
  fw_sel_e      fw_b_sel_i;
  jalr_fw_sel_e jalr_fw_sel_i;
  word_t        rf_wdata_ex_i;
  logic         rf_we_wb_i;
  rf_addr_t     rf_waddr_wb_i;
  word_t        rf_wdata_wb_i;
  logic         id_ready_o;
  logic         id_valid_o;
  logic         clear_instr_valid_o;
  logic         branch_taken_ex_o;
  word_t        jmp_target_o;
  logic         ex_alu_en_o;
  alu_op_e      ex_alu_operator_o;
  word_t        ex_operand_a_o;
  word_t        ex_operand_b_o;
  word_t        ex_operand_c_o;
  logic         ex_rf_we_o;
  rf_addr_t     ex_rf_waddr_o;
  logic         ex_data_req_o;
  logic         ex_data_we_o;
  logic [1:0]   ex_data_type_o;
  logic         ex_branch_in_ex_o;
  logic         ex_illegal_insn_o;
  word_t        ex_pc_o;

  row_t  rows  [NUM_ROWS];
  string names [NUM_ROWS];
  int    errors;
  int    checks;
  logic  ready_ok;

  id_stage_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Stimulus table
  ////////////////////

  // x1..x7 hold k * 0x1111, fw inputs hold FW_EX_VAL and FW_WB_VAL
  task automatic fill_table();
    names[0]  = "addi";
    rows[0]   = '{32'hFFD0_8293, 32'h100, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h1111, 32'hFFFF_FFFD, 32'h0, ALU_ADD, 1'b1, 5'd5, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h100};
    names[1]  = "sub";
    rows[1]   = '{32'h4021_8333, 32'h104, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h3333, 32'h2222, 32'h0, ALU_SUB, 1'b1, 5'd6, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h104};
    names[2]  = "srai";
    rows[2]   = '{32'h4032_5393, 32'h108, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h4444, 32'h403, 32'h0, ALU_SRA, 1'b1, 5'd7, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h108};
    names[3]  = "lui";
    rows[3]   = '{32'hABCD_E4B7, 32'h10C, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h0, 32'hABCD_E000, 32'h0, ALU_ADD, 1'b1, 5'd9, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h10C};
    names[4]  = "auipc";
    rows[4]   = '{32'h0001_2517, 32'h200, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h200, 32'h1_2000, 32'h0, ALU_ADD, 1'b1, 5'd10, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h200};
    // Jumps link to PC + 4
    names[5]  = "jal";
    rows[5]   = '{32'h0400_00EF, 32'h300, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h300, 32'h4, 32'h0, ALU_ADD, 1'b1, 5'd1, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b1, 32'h340, 1'b1, 1'b0, 32'h300};
    names[6]  = "jalr";
    rows[6]   = '{32'h0081_8167, 32'h304, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h304, 32'h4, 32'h0, ALU_ADD, 1'b1, 5'd2, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b1, 32'h333A, 1'b1, 1'b0, 32'h304};
    names[7]  = "jalr_fw_wb";
    rows[7]   = '{32'hFFD2_8167, 32'h308, SEL_REGFILE, SEL_REGFILE, SELJ_FW_WB, 4'b1000, 1'b0,
                  32'h308, 32'h4, 32'h0, ALU_ADD, 1'b1, 5'd2, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b1, 32'h0001_2344, 1'b1, 1'b0, 32'h308};
    // Branch target rides on operand C
    names[8]  = "beq_taken";
    rows[8]   = '{32'h0010_8863, 32'h400, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b1,
                  32'h1111, 32'h1111, 32'h410, ALU_EQ, 1'b0, 5'd16, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b1, 1'b0, 32'h0, 1'b1, 1'b1, 32'h400};
    names[9]  = "bltu_not_taken";
    rows[9]   = '{32'hFE31_6CE3, 32'h420, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h2222, 32'h3333, 32'h418, ALU_LTU, 1'b0, 5'd25, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, 32'h420};
    names[10] = "lw";
    rows[10]  = '{32'h00C2_2583, 32'h500, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h4444, 32'hC, 32'h0, ALU_ADD, 1'b1, 5'd11, 1'b1, 1'b0, 2'd2,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h500};
    names[11] = "sb";
    rows[11]  = '{32'hFE62_8FA3, 32'h504, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h5555, 32'hFFFF_FFFF, 32'h6666, ALU_ADD, 1'b0, 5'd31, 1'b1, 1'b1, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h504};
    names[12] = "fw_ex_wb";
    rows[12]  = '{32'h0020_8633, 32'h508, SEL_FW_EX, SEL_FW_WB, SELJ_REGFILE, 4'b1000, 1'b0,
                  FW_EX_VAL, FW_WB_VAL, 32'h0, ALU_ADD, 1'b1, 5'd12, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h508};
    names[13] = "x0_read";
    rows[13]  = '{32'h0000_0733, 32'h50C, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h0, 32'h0, 32'h0, ALU_ADD, 1'b1, 5'd14, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h50C};
    // Operands hold, the ALU is not enabled
    names[14] = "illegal";
    rows[14]  = '{32'h0020_807F, 32'h600, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h0, 32'h0, 32'h0, ALU_ADD, 1'b0, 5'd0, 1'b0, 1'b0, 2'd0,
                  1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h600};
    names[15] = "load_stall";
    rows[15]  = '{32'hFFD0_8293, 32'h604, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1100, 1'b0,
                  32'h0, 32'h0, 32'h0, ALU_ADD, 1'b0, 5'd0, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h600};
    names[16] = "resume";
    rows[16]  = '{32'hFFD0_8293, 32'h604, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h1111, 32'hFFFF_FFFD, 32'h0, ALU_ADD, 1'b1, 5'd5, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h604};
    names[17] = "halt";
    rows[17]  = '{32'h4021_8333, 32'h608, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1001, 1'b0,
                  32'h1111, 32'hFFFF_FFFD, 32'h0, ALU_ADD, 1'b0, 5'd5, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h604};
    names[18] = "store_again";
    rows[18]  = '{32'hFE62_8FA3, 32'h60C, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1000, 1'b0,
                  32'h5555, 32'hFFFF_FFFF, 32'h6666, ALU_ADD, 1'b0, 5'd31, 1'b1, 1'b1, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h60C};
    // EX not ready, the store stays put
    names[19] = "ex_not_ready";
    rows[19]  = '{32'h00C2_2583, 32'h610, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b0000, 1'b0,
                  32'h5555, 32'hFFFF_FFFF, 32'h6666, ALU_ADD, 1'b0, 5'd31, 1'b1, 1'b1, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 32'h60C};
    names[20] = "jr_stall";
    rows[20]  = '{32'h00C2_2583, 32'h610, SEL_REGFILE, SEL_REGFILE, SELJ_REGFILE, 4'b1010, 1'b0,
                  32'h5555, 32'hFFFF_FFFF, 32'h6666, ALU_ADD, 1'b0, 5'd31, 1'b0, 1'b0, 2'd0,
                  1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h60C};
  endtask

  ////////////////////
  // Drive and check
  ////////////////////

  task automatic check(input string name, input string field, input word_t exp,
                       input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s %s expected %h actual %h", name, field, exp, act);
    end
  endtask

  // Decision belongs to the instruction now in EX
  task automatic drive_row(input int i, input logic bdec);
    instr_i           <= rows[i].instr;
    pc_i              <= rows[i].pc;
    fw_a_sel_i        <= rows[i].fw_a;
    fw_b_sel_i        <= rows[i].fw_b;
    jalr_fw_sel_i     <= rows[i].fw_j;
    ex_ready_i        <= rows[i].lvl[3];
    load_stall_i      <= rows[i].lvl[2];
    jr_stall_i        <= rows[i].lvl[1];
    halt_id_i         <= rows[i].lvl[0];
    branch_decision_i <= bdec;
  endtask

  // nop, no stalls
  task automatic drive_idle(input logic bdec);
    instr_i           <= 32'h0000_0013;
    pc_i              <= '0;
    fw_a_sel_i        <= SEL_REGFILE;
    fw_b_sel_i        <= SEL_REGFILE;
    jalr_fw_sel_i     <= SELJ_REGFILE;
    ex_ready_i        <= 1'b1;
    load_stall_i      <= 1'b0;
    jr_stall_i        <= 1'b0;
    halt_id_i         <= 1'b0;
    branch_decision_i <= bdec;
  endtask

  // Handshake levels and jump target of the row being presented
  task automatic check_comb(input int i);
    logic rdy;
    logic vld;
    logic clr;
    rdy = rows[i].lvl[3] & ~rows[i].lvl[2] & ~rows[i].lvl[1];
    vld = rdy & ~rows[i].lvl[0];
    // Previous row sits in EX with its branch decision
    clr = rdy | rows[i].lvl[0];
    if (i > 0) clr = clr | rows[i - 1].taken;
    check(names[i], "id_ready", 32'(rdy), 32'(id_ready_o));
    check(names[i], "id_valid", 32'(vld), 32'(id_valid_o));
    check(names[i], "clear_instr_valid", 32'(clr), 32'(clear_instr_valid_o));
    if (rows[i].jmp_chk) begin
      check(names[i], "jmp_target", rows[i].jmp, jmp_target_o);
    end
  endtask

  task automatic check_ex(input int i);
    check(names[i], "operand_a", rows[i].op_a, ex_operand_a_o);
    check(names[i], "operand_b", rows[i].op_b, ex_operand_b_o);
    check(names[i], "operand_c", rows[i].op_c, ex_operand_c_o);
    check(names[i], "alu_op", 32'(rows[i].alu_op), 32'(ex_alu_operator_o));
    check(names[i], "alu_en", 32'(rows[i].alu_en), 32'(ex_alu_en_o));
    check(names[i], "rf_we", 32'(rows[i].rf_we), 32'(ex_rf_we_o));
    check(names[i], "rd", 32'(rows[i].rd), 32'(ex_rf_waddr_o));
    check(names[i], "data_req", 32'(rows[i].req), 32'(ex_data_req_o));
    // LSU fields mean nothing without a request
    if (rows[i].req) begin
      check(names[i], "data_we", 32'(rows[i].dwe), 32'(ex_data_we_o));
      check(names[i], "data_type", 32'(rows[i].dtype), 32'(ex_data_type_o));
    end
    check(names[i], "illegal", 32'(rows[i].ill), 32'(ex_illegal_insn_o));
    check(names[i], "branch_in_ex", 32'(rows[i].br_in_ex), 32'(ex_branch_in_ex_o));
    check(names[i], "branch_taken", 32'(rows[i].taken), 32'(branch_taken_ex_o));
    check(names[i], "pc", rows[i].ex_pc, ex_pc_o);
  endtask

  task automatic apply_reset();
    rst_n         <= 1'b0;
    rf_wdata_ex_i <= FW_EX_VAL;
    rf_we_wb_i    <= 1'b0;
    rf_waddr_wb_i <= '0;
    rf_wdata_wb_i <= '0;
    drive_idle(1'b0);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // xk = k * 0x1111 through the WB port
  task automatic preload_regs();
    for (int k = 1; k < 8; k++) begin
      @(posedge clk);
      rf_we_wb_i    <= 1'b1;
      rf_waddr_wb_i <= rf_addr_t'(k);
      rf_wdata_wb_i <= word_t'(k * 32'h1111);
    end
    // x0 has to drop this one
    @(posedge clk);
    rf_we_wb_i    <= 1'b1;
    rf_waddr_wb_i <= '0;
    rf_wdata_wb_i <= 32'hFFFF_0000;
    @(posedge clk);
    rf_we_wb_i    <= 1'b0;
    rf_waddr_wb_i <= '0;
    rf_wdata_wb_i <= FW_WB_VAL;
  endtask

  task automatic wait_ready(output logic ok);
    ok = 1'b0;
    for (int n = 0; n < READY_MAX && !ok; n++) begin
      @(negedge clk);
      if (id_ready_o === 1'b1) ok = 1'b1;
    end
    if (!ok) $display("Timeout: id_ready_o stayed low after reset");
  endtask

  // One row per cycle, EX result checked one cycle after issue
  task automatic run_table();
    @(posedge clk);
    drive_row(0, 1'b0);
    for (int i = 0; i <= NUM_ROWS; i++) begin
      @(negedge clk);
      if (i > 0) check_ex(i - 1);
      if (i < NUM_ROWS) begin
        check_comb(i);
        @(posedge clk);
        if (i + 1 < NUM_ROWS) drive_row(i + 1, rows[i].bdec);
        else drive_idle(rows[i].bdec);
      end
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    fill_table();
    apply_reset();
    preload_regs();
    wait_ready(ready_ok);
    if (ready_ok) run_table();
    $display("%0d checks, %0d errors", checks, errors);
    if (ready_ok && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_regfile.sv
logic/id_operand_select.sv
logic/id_ex_register.sv
logic/id_stage_top.sv
bench/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build the ID stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_id_stage -o tb_id_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_id_stage_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
